// File: source/nes_host_pkg.sv
// shared widths, request structs and constants for the emulator host glue
// every design file refers to these by scoped name

`default_nettype none

package nes_host_pkg;

    //////////////////////////////////////////////////
    // widths
    //////////////////////////////////////////////////
    localparam int MEM_ADDR_W = 20;   // halfword address on the 16-bit port
    localparam int RV_ADDR_W  = 23;   // soft-core byte address
    localparam int CPU_ADDR_W = 22;   // console / loader byte address

    // mappers with expansion audio
    localparam logic [7:0] MAPPER_VRC6A = 8'd24;
    localparam logic [7:0] MAPPER_VRC6B = 8'd26;
    localparam logic [7:0] MAPPER_N163  = 8'd19;

    //////////////////////////////////////////////////
    // soft-core and 16-bit memory port
    //////////////////////////////////////////////////
    typedef struct packed {
        logic                 valid;
        logic [RV_ADDR_W-1:0] addr;
        logic [31:0]          wdata;
        logic [3:0]           wstrb;   // all zero is a read
    } rv_req_t;

    typedef struct packed {
        logic                  req;    // toggles once per request
        logic [MEM_ADDR_W-1:0] addr;
        logic [15:0]           din;
        logic [1:0]            ds;
        logic                  we;
    } mem16_req_t;

    typedef enum logic [2:0] {
        IDLE_REQ0,
        WAIT0_REQ1,
        DATA0,
        WAIT1,
        DATA1
    } rv_state_e;

    //////////////////////////////////////////////////
    // pads
    //////////////////////////////////////////////////
    typedef struct packed {
        logic [7:0] byte1;   // shape buttons, active low
        logic [7:0] byte0;   // dpad and start/select, active low
    } pad_rx_t;

    typedef struct packed {
        logic r;
        logic l;
        logic d;
        logic u;
        logic start;
        logic select;
        logic b;
        logic a;
    } nes_buttons_t;

    //////////////////////////////////////////////////
    // loader and console CPU port
    //////////////////////////////////////////////////
    typedef struct packed {
        logic                  write;
        logic [CPU_ADDR_W-1:0] addr;
        logic [7:0]            data;
    } loader_wr_t;

    typedef struct packed {
        logic [CPU_ADDR_W-1:0] addr;
        logic                  read;
        logic                  write;
        logic [7:0]            dout;
    } cpu_mem_t;

    typedef struct packed {
        logic [CPU_ADDR_W-1:0] addr;
        logic                  we;
        logic                  oe;
        logic [7:0]            din;
    } mem8_req_t;

    typedef logic [63:0] mapper_flags_t;

endpackage

`default_nettype wire

// File: source/rv_mem_bridge.sv
// splits a 32-bit soft-core access into one or two 16-bit requests
// on the toggle req/ack memory port; o_rv_ready pulses once at the end

`timescale 1ns/1ps
`default_nettype none

module rv_mem_bridge (
    input  wire                       clk,
    input  wire                       sys_resetn,
    input  nes_host_pkg::rv_req_t     i_rv,
    output logic                      o_rv_ready,
    output logic [31:0]               o_rv_rdata,
    output nes_host_pkg::mem16_req_t  o_mem,
    input  wire                       i_mem_ack,
    input  wire [15:0]                i_mem_dout
);

    nes_host_pkg::rv_state_e state;

    logic        valid_r;
    logic        pending;     // edge seen while busy
    logic        req;
    logic        word;        // 0 lower half, 1 upper half
    logic [1:0]  ds;
    logic [15:0] dout0;       // lower half of a read

    logic        new_req;
    logic        is_write;

    assign new_req  = i_rv.valid & ~valid_r;
    assign is_write = |i_rv.wstrb;

    //////////////////////////////////////////////////
    // memory port
    //////////////////////////////////////////////////
    always_comb begin
        o_mem.req  = req;
        o_mem.addr = {i_rv.addr[20:2], word};
        o_mem.din  = word ? i_rv.wdata[31:16] : i_rv.wdata[15:0];
        o_mem.ds   = ds;
        o_mem.we   = is_write;
    end

    assign o_rv_rdata = {i_mem_dout, dout0};   // upper half still live in DATA1

    //////////////////////////////////////////////////
    // request FSM
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!sys_resetn) begin
            state      <= nes_host_pkg::IDLE_REQ0;
            o_rv_ready <= 1'b0;
            valid_r    <= 1'b0;
            pending    <= 1'b0;
            req        <= 1'b0;
        end else begin
            valid_r    <= i_rv.valid;
            o_rv_ready <= 1'b0;
            if (new_req)
                pending <= 1'b1;

            case (state)
                nes_host_pkg::IDLE_REQ0: begin
                    if (pending || new_req) begin
                        pending <= 1'b0;
                        req     <= ~req;
                        if (is_write && i_rv.wstrb[1:0] == 2'b00) begin
                            // upper half only
                            word  <= 1'b1;
                            ds    <= i_rv.wstrb[3:2];
                            state <= nes_host_pkg::WAIT1;
                        end else begin
                            word  <= 1'b0;
                            ds    <= is_write ? i_rv.wstrb[1:0] : 2'b11;
                            state <= nes_host_pkg::WAIT0_REQ1;
                        end
                    end
                end

                nes_host_pkg::WAIT0_REQ1: begin
                    if (req == i_mem_ack) begin
                        if (is_write && i_rv.wstrb[3:2] == 2'b00) begin
                            o_rv_ready <= 1'b1;        // lower half only, done
                            state      <= nes_host_pkg::IDLE_REQ0;
                        end else begin
                            req  <= ~req;              // second request
                            word <= 1'b1;
                            ds   <= is_write ? i_rv.wstrb[3:2] : 2'b11;
                            if (is_write)
                                state <= nes_host_pkg::WAIT1;
                            else
                                state <= nes_host_pkg::DATA0;
                        end
                    end
                end

                nes_host_pkg::DATA0: begin
                    dout0 <= i_mem_dout;
                    state <= nes_host_pkg::WAIT1;
                end

                nes_host_pkg::WAIT1: begin
                    if (req == i_mem_ack) begin
                        if (is_write) begin
                            o_rv_ready <= 1'b1;
                            state      <= nes_host_pkg::IDLE_REQ0;
                        end else begin
                            state <= nes_host_pkg::DATA1;
                        end
                    end
                end

                nes_host_pkg::DATA1: begin
                    o_rv_ready <= 1'b1;
                    state      <= nes_host_pkg::IDLE_REQ0;
                end

                default: state <= nes_host_pkg::IDLE_REQ0;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: source/pad_serializer.sv
// one controller port: maps dualshock bytes to console button order,
// loads on strobe and shifts out A first on each falling pad clock

`timescale 1ns/1ps
`default_nettype none

module pad_serializer (
    input  wire                    clk,
    input  wire                    sys_resetn,
    input  nes_host_pkg::pad_rx_t  i_pad,
    input  wire                    i_strobe,
    input  wire                    i_pad_clk,
    output logic                   o_data
);

    nes_host_pkg::nes_buttons_t btn;

    logic [7:0] shift_q;
    logic       pad_clk_r;
    logic       clk_fall;

    // pad bytes are active low, console buttons active high
    always_comb begin
        btn.r      = ~i_pad.byte0[5];
        btn.l      = ~i_pad.byte0[7];
        btn.d      = ~i_pad.byte0[6];
        btn.u      = ~i_pad.byte0[4];
        btn.start  = ~i_pad.byte0[3];
        btn.select = ~i_pad.byte0[0];
        btn.b      = ~i_pad.byte1[6];   // cross
        btn.a      = ~i_pad.byte1[5];   // circle
    end

    assign clk_fall = pad_clk_r & ~i_pad_clk;

    always_ff @(posedge clk) begin
        if (!sys_resetn) begin
            shift_q   <= 8'hff;
            pad_clk_r <= 1'b0;
        end else begin
            pad_clk_r <= i_pad_clk;
            if (i_strobe)
                shift_q <= btn;
            if (clk_fall)                        // wins over strobe
                shift_q <= {1'b1, shift_q[7:1]};
        end
    end

    assign o_data = shift_q[0];

endmodule

`default_nettype wire

// File: source/load_sequencer.sv
// console reset and clock reference around a ROM load, loader write
// stretch, CPU memory port mux and mapper flag latch

`timescale 1ns/1ps
`default_nettype none

module load_sequencer (
    input  wire                          clk,
    input  wire                          sys_resetn,
    input  wire                          i_loading,
    input  nes_host_pkg::loader_wr_t     i_loader_wr,
    input  wire                          i_loader_done,
    input  nes_host_pkg::mapper_flags_t  i_loader_flags,
    input  nes_host_pkg::cpu_mem_t       i_cpu_mem,
    output nes_host_pkg::mem8_req_t      o_mem_b,
    output logic                         o_loader_reset,
    output logic                         o_reset_nes,
    output logic                         o_clkref,
    output nes_host_pkg::mapper_flags_t  o_mapper_flags,
    output logic                         o_ext_audio
);

    logic                                loading_r;
    logic                                wr_r;
    logic                                wr_stretch;   // two cycles wide
    logic [nes_host_pkg::CPU_ADDR_W-1:0] ld_addr;
    logic [7:0]                          ld_data;

    //////////////////////////////////////////////////
    // reset and clock reference
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!sys_resetn) begin
            loading_r      <= 1'b0;
            o_loader_reset <= 1'b0;
            o_reset_nes    <= 1'b1;
            o_clkref       <= 1'b0;
        end else begin
            loading_r      <= i_loading;
            o_loader_reset <= i_loading & ~loading_r;
            o_clkref       <= ~o_clkref;
            if (!i_loading && loading_r) begin
                o_reset_nes <= 1'b0;
                o_clkref    <= 1'b1;   // restart phase
            end else if (i_loading && !loading_r) begin
                o_reset_nes <= 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////
    // loader writes and mapper flags
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!sys_resetn) begin
            wr_r           <= 1'b0;
            wr_stretch     <= 1'b0;
            o_mapper_flags <= '0;
        end else begin
            wr_r       <= i_loader_wr.write;
            wr_stretch <= i_loader_wr.write | wr_r;
            if (i_loader_done)
                o_mapper_flags <= i_loader_flags;
        end
    end

    always_ff @(posedge clk) begin
        if (i_loader_wr.write) begin
            ld_addr <= i_loader_wr.addr;
            ld_data <= i_loader_wr.data;
        end
    end

    // loader owns the port for the whole load
    always_comb begin
        o_mem_b.addr = i_loading ? ld_addr : i_cpu_mem.addr;
        o_mem_b.din  = i_loading ? ld_data : i_cpu_mem.dout;
        o_mem_b.oe   = ~i_loading & i_cpu_mem.read;
        o_mem_b.we   = wr_stretch | i_cpu_mem.write;
    end

    assign o_ext_audio = (o_mapper_flags[7:0] == nes_host_pkg::MAPPER_VRC6A) |
                         (o_mapper_flags[7:0] == nes_host_pkg::MAPPER_VRC6B) |
                         (o_mapper_flags[7:0] == nes_host_pkg::MAPPER_N163);

endmodule

`default_nettype wire

// File: source/nes_host_top.sv
// host side glue of the emulator: soft-core memory bridge, two pad
// serializers and the ROM load sequencer; instances only

`timescale 1ns/1ps
`default_nettype none

module nes_host_top (
    input  wire                          clk,
    input  wire                          sys_resetn,
    // soft-core
    input  nes_host_pkg::rv_req_t        i_rv,
    output logic                         o_rv_ready,
    output logic [31:0]                  o_rv_rdata,
    output nes_host_pkg::mem16_req_t     o_mem,
    input  wire                          i_mem_ack,
    input  wire [15:0]                   i_mem_dout,
    // pads
    input  wire                          i_joy_strobe,
    input  wire [1:0]                    i_joy_clk,
    input  nes_host_pkg::pad_rx_t        i_pad1,
    input  nes_host_pkg::pad_rx_t        i_pad2,
    output logic [1:0]                   o_joy_data,
    // loader and console CPU
    input  wire                          i_loading,
    input  nes_host_pkg::loader_wr_t     i_loader_wr,
    input  wire                          i_loader_done,
    input  nes_host_pkg::mapper_flags_t  i_loader_flags,
    input  nes_host_pkg::cpu_mem_t       i_cpu_mem,
    output nes_host_pkg::mem8_req_t      o_mem_b,
    output logic                         o_loader_reset,
    output logic                         o_reset_nes,
    output logic                         o_clkref,
    output nes_host_pkg::mapper_flags_t  o_mapper_flags,
    output logic                         o_ext_audio
);

    rv_mem_bridge u_bridge (
        .clk        (clk),
        .sys_resetn (sys_resetn),
        .i_rv       (i_rv),
        .o_rv_ready (o_rv_ready),
        .o_rv_rdata (o_rv_rdata),
        .o_mem      (o_mem),
        .i_mem_ack  (i_mem_ack),
        .i_mem_dout (i_mem_dout)
    );

    //////////////////////////////////////////////////
    // controller ports
    //////////////////////////////////////////////////
    pad_serializer u_pad1 (
        .clk        (clk),
        .sys_resetn (sys_resetn),
        .i_pad      (i_pad1),
        .i_strobe   (i_joy_strobe),
        .i_pad_clk  (i_joy_clk[0]),
        .o_data     (o_joy_data[0])
    );

    pad_serializer u_pad2 (
        .clk        (clk),
        .sys_resetn (sys_resetn),
        .i_pad      (i_pad2),
        .i_strobe   (i_joy_strobe),   // shared strobe
        .i_pad_clk  (i_joy_clk[1]),
        .o_data     (o_joy_data[1])
    );

    load_sequencer u_loadseq (
        .clk            (clk),
        .sys_resetn     (sys_resetn),
        .i_loading      (i_loading),
        .i_loader_wr    (i_loader_wr),
        .i_loader_done  (i_loader_done),
        .i_loader_flags (i_loader_flags),
        .i_cpu_mem      (i_cpu_mem),
        .o_mem_b        (o_mem_b),
        .o_loader_reset (o_loader_reset),
        .o_reset_nes    (o_reset_nes),
        .o_clkref       (o_clkref),
        .o_mapper_flags (o_mapper_flags),
        .o_ext_audio    (o_ext_audio)
    );

endmodule

`default_nettype wire

// File: verif/tb_checks.svh
// typed compare tasks and the wait for the soft-core ready pulse
// included inside the testbench module body

`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp)
        report_failure($sformatf("** Error: %s = 0x%h, expected 0x%h", name, got, exp));
endtask

task automatic check_word32(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
    if (got !== exp)
        report_failure($sformatf("** Error: %s = 0x%h, expected 0x%h", name, got, exp));
endtask

task automatic check_mem8(input string name, input nes_host_pkg::mem8_req_t got,
                          input nes_host_pkg::mem8_req_t exp);
    if (got !== exp)
        report_failure($sformatf("** Error: %s = 0x%h, expected 0x%h", name, got, exp));
endtask

task automatic check_flags(input string name, input nes_host_pkg::mapper_flags_t got,
                           input nes_host_pkg::mapper_flags_t exp);
    if (got !== exp)
        report_failure($sformatf("** Error: %s = 0x%h, expected 0x%h", name, got, exp));
endtask

// polls once per falling edge
task automatic wait_rv_ready(input int limit);
    int n;
    n = 0;
    while (o_rv_ready !== 1'b1) begin
        if (n == limit) begin
            report_failure($sformatf("o_rv_ready never pulsed within %0d cycles", limit));
        end else begin
            @(negedge clk);
            n++;
        end
    end
endtask

`endif

// File: verif/tb_nes_host_top.sv
// directed testbench for the emulator host glue
// 16-bit memory model with random ack latency, then soft-core, pad,
// load sequence and CPU port tests in that order

`timescale 1ns/1ps
`default_nettype none

module tb_nes_host_top;

    logic                         clk = 1'b0;
    logic                         sys_resetn;
    nes_host_pkg::rv_req_t        i_rv;
    logic                         o_rv_ready;
    logic [31:0]                  o_rv_rdata;
    nes_host_pkg::mem16_req_t     o_mem;
    logic                         i_mem_ack;
    logic [15:0]                  i_mem_dout;
    logic                         i_joy_strobe;
    logic [1:0]                   i_joy_clk;
    nes_host_pkg::pad_rx_t        i_pad1;
    nes_host_pkg::pad_rx_t        i_pad2;
    logic [1:0]                   o_joy_data;
    logic                         i_loading;
    nes_host_pkg::loader_wr_t     i_loader_wr;
    logic                         i_loader_done;
    nes_host_pkg::mapper_flags_t  i_loader_flags;
    nes_host_pkg::cpu_mem_t       i_cpu_mem;
    nes_host_pkg::mem8_req_t      o_mem_b;
    logic                         o_loader_reset;
    logic                         o_reset_nes;
    logic                         o_clkref;
    nes_host_pkg::mapper_flags_t  o_mapper_flags;
    logic                         o_ext_audio;

    integer      seed = 32'hb1497bb8;
    logic [15:0] hmem    [32];   // memory model, halfwords
    logic [15:0] ref_mem [32];   // expected memory contents
    logic        seen_req;
    logic [4:0]  req_addr;
    int          ack_delay;

    nes_host_top uut (.*);

    always #50 clk = ~clk;

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("*** FAILED ***");
        $fatal(1, "stopped at first error");
    endtask

    `include "tb_checks.svh"

    function automatic logic [31:0] rand32();
        return $random(seed);
    endfunction

    function automatic logic [15:0] fill_value(input logic [4:0] a);
        return {a, 3'b101, a, 3'b010} ^ 16'h3c96;
    endfunction

    // pad bytes are active low; result is R L D U Start Select B A
    function automatic nes_host_pkg::nes_buttons_t map_pad(input nes_host_pkg::pad_rx_t p);
        return ~{p.byte0[5], p.byte0[7], p.byte0[6], p.byte0[4],
                 p.byte0[3], p.byte0[0], p.byte1[6], p.byte1[5]};
    endfunction

    //////////////////////////////////////////////////
    // 16-bit memory model
    //////////////////////////////////////////////////
    always @(negedge clk) begin
        if (!sys_resetn) begin
            seen_req  = 1'b0;
            ack_delay = 0;
        end else if (o_mem.req !== seen_req) begin
            seen_req = o_mem.req;
            if (o_mem.addr[19:5] != '0)
                report_failure("memory request outside the modelled range");
            req_addr = o_mem.addr[4:0];
            if (o_mem.we && o_mem.ds[0])
                hmem[req_addr][7:0] = o_mem.din[7:0];
            if (o_mem.we && o_mem.ds[1])
                hmem[req_addr][15:8] = o_mem.din[15:8];
            ack_delay = 1 + ({$random(seed)} % 4);   // 1 to 4 cycles
        end else if (ack_delay > 0) begin
            ack_delay = ack_delay - 1;
            if (ack_delay == 0) begin
                i_mem_dout = hmem[req_addr];   // held until the next ack
                i_mem_ack  = seen_req;
            end
        end
    end

    //////////////////////////////////////////////////
    // test tasks
    //////////////////////////////////////////////////
    task automatic rv_access(input logic [22:0] addr, input logic [31:0] wdata,
                             input logic [3:0] wstrb, output logic [31:0] rdata);
        @(negedge clk);
        i_rv.addr  = addr;
        i_rv.wdata = wdata;
        i_rv.wstrb = wstrb;
        i_rv.valid = 1'b1;
        wait_rv_ready(64);
        rdata      = o_rv_rdata;
        i_rv.valid = 1'b0;
        repeat (3) begin
            @(negedge clk);
            check_bit("o_rv_ready", o_rv_ready, 1'b0);   // one pulse only
        end
    endtask

    task automatic test_softcore();
        logic [3:0]  widx_q [$];
        logic [3:0]  w;
        logic [31:0] rnd;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
        logic [31:0] rdata;
        logic [4:0]  lo;
        logic [4:0]  hi;
        for (int i = 0; i < 12; i++) begin
            rnd   = rand32();
            w     = rnd[3:0];
            wstrb = rnd[7:4];
            wdata = rand32();
            lo    = {w, 1'b0};
            hi    = {w, 1'b1};
            widx_q.push_back(w);
            rv_access({17'd0, w, 2'b00}, wdata, wstrb, rdata);
            if (wstrb == 4'h0)   // no strobes is a read
                check_word32("o_rv_rdata", rdata, {ref_mem[hi], ref_mem[lo]});
            if (wstrb[0])
                ref_mem[lo][7:0] = wdata[7:0];
            if (wstrb[1])
                ref_mem[lo][15:8] = wdata[15:8];
            if (wstrb[2])
                ref_mem[hi][7:0] = wdata[23:16];
            if (wstrb[3])
                ref_mem[hi][15:8] = wdata[31:24];
            check_word32("memory word", {hmem[hi], hmem[lo]}, {ref_mem[hi], ref_mem[lo]});
        end
        while (widx_q.size() > 0) begin
            w  = widx_q.pop_front();
            lo = {w, 1'b0};
            hi = {w, 1'b1};
            rv_access({17'd0, w, 2'b00}, rand32(), 4'h0, rdata);
            check_word32("o_rv_rdata", rdata, {ref_mem[hi], ref_mem[lo]});
        end
    endtask

    task automatic test_pads();
        logic [31:0] rnd;
        logic [7:0]  exp1;
        logic [7:0]  exp2;
        rnd = rand32();
        @(negedge clk);
        i_pad1       = rnd[15:0];
        i_pad2       = rnd[31:16];
        exp1         = map_pad(rnd[15:0]);
        exp2         = map_pad(rnd[31:16]);
        i_joy_strobe = 1'b1;
        @(negedge clk);
        i_joy_strobe = 1'b0;
        for (int k = 0; k < 10; k++) begin   // 8 buttons, then two idle bits
            check_bit("o_joy_data[0]", o_joy_data[0], exp1[0]);
            check_bit("o_joy_data[1]", o_joy_data[1], exp2[0]);
            exp1      = {1'b1, exp1[7:1]};
            i_joy_clk = 2'b11;
            @(negedge clk);
            i_joy_clk = 2'b10;   // port 1 falls first
            @(negedge clk);
            check_bit("o_joy_data[0]", o_joy_data[0], exp1[0]);
            check_bit("o_joy_data[1]", o_joy_data[1], exp2[0]);
            exp2      = {1'b1, exp2[7:1]};
            i_joy_clk = 2'b00;   // then port 2
            @(negedge clk);
        end
        check_bit("o_joy_data[0]", o_joy_data[0], 1'b1);
        check_bit("o_joy_data[1]", o_joy_data[1], 1'b1);
    endtask

    task automatic latch_flags(input logic [7:0] mapper);
        nes_host_pkg::mapper_flags_t flags;
        logic [31:0]                 rnd;
        logic                        exp_audio;
        rnd       = rand32();
        flags     = {rand32(), rnd[31:8], mapper};
        exp_audio = (mapper == 8'd24) || (mapper == 8'd26) || (mapper == 8'd19);
        @(negedge clk);
        i_loader_flags = flags;
        i_loader_done  = 1'b1;
        @(negedge clk);
        i_loader_done = 1'b0;
        check_flags("o_mapper_flags", o_mapper_flags, flags);
        check_bit("o_ext_audio", o_ext_audio, exp_audio);
    endtask

    task automatic test_load();
        nes_host_pkg::mem8_req_t exp;
        logic [31:0]             rnd;
        logic                    exp_ref;
        @(negedge clk);
        i_cpu_mem = '{addr: 22'h2a5a5, read: 1'b1, write: 1'b0, dout: 8'h77};
        i_loading = 1'b1;
        @(negedge clk);
        check_bit("o_loader_reset", o_loader_reset, 1'b1);
        check_bit("o_reset_nes", o_reset_nes, 1'b1);
        rnd         = rand32();
        i_loader_wr = '{write: 1'b1, addr: rnd[21:0], data: rnd[31:24]};
        @(negedge clk);
        check_bit("o_loader_reset", o_loader_reset, 1'b0);
        i_loader_wr = '{write: 1'b0, addr: ~rnd[21:0], data: ~rnd[31:24]};
        exp         = '{addr: rnd[21:0], we: 1'b1, oe: 1'b0, din: rnd[31:24]};
        check_mem8("o_mem_b", o_mem_b, exp);
        @(negedge clk);
        check_mem8("o_mem_b", o_mem_b, exp);   // second stretched cycle
        @(negedge clk);
        exp.we = 1'b0;
        check_mem8("o_mem_b", o_mem_b, exp);
        latch_flags(8'd24);
        latch_flags(8'd26);
        latch_flags(8'd19);
        latch_flags(8'd4);
        i_loading = 1'b0;
        @(negedge clk);
        check_bit("o_reset_nes", o_reset_nes, 1'b0);
        check_bit("o_clkref", o_clkref, 1'b1);
        exp_ref = 1'b1;
        repeat (4) begin
            @(negedge clk);
            exp_ref = ~exp_ref;
            check_bit("o_clkref", o_clkref, exp_ref);
        end
    endtask

    task automatic test_cpu_port();
        nes_host_pkg::mem8_req_t exp;
        logic [31:0]             rnd;
        repeat (8) begin
            @(negedge clk);
            rnd       = rand32();
            i_cpu_mem = '{addr: rnd[21:0], read: rnd[22], write: rnd[23], dout: rnd[31:24]};
            exp       = '{addr: rnd[21:0], we: rnd[23], oe: rnd[22], din: rnd[31:24]};
            @(negedge clk);
            check_mem8("o_mem_b", o_mem_b, exp);
        end
    endtask

    //////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////
    initial begin
        sys_resetn     = 1'b0;
        i_rv           = '0;
        i_mem_ack      = 1'b0;
        i_mem_dout     = '0;
        i_joy_strobe   = 1'b0;
        i_joy_clk      = 2'b00;
        i_pad1         = '1;
        i_pad2         = '1;
        i_loading      = 1'b0;
        i_loader_wr    = '0;
        i_loader_done  = 1'b0;
        i_loader_flags = '0;
        i_cpu_mem      = '0;
        for (logic [5:0] a = 0; a < 32; a++) begin
            hmem[a[4:0]]    = fill_value(a[4:0]);
            ref_mem[a[4:0]] = fill_value(a[4:0]);
        end

        repeat (16) @(negedge clk);
        sys_resetn = 1'b1;
        @(negedge clk);
        check_bit("o_rv_ready", o_rv_ready, 1'b0);
        check_bit("o_reset_nes", o_reset_nes, 1'b1);
        check_flags("o_mapper_flags", o_mapper_flags, '0);
        check_bit("o_joy_data[0]", o_joy_data[0], 1'b1);
        check_bit("o_joy_data[1]", o_joy_data[1], 1'b1);

        test_softcore();
        test_pads();
        test_load();
        @(negedge clk);   // odd gap flips the free-running clkref phase
        test_load();      // second pass starts from a running console
        test_cpu_port();

        repeat (2) @(negedge clk);
        $display("*** PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
+incdir+verif
source/nes_host_pkg.sv
source/rv_mem_bridge.sv
source/pad_serializer.sv
source/load_sequencer.sv
source/nes_host_top.sv
verif/tb_nes_host_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it and reports the result

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing -f all.f --top-module tb_nes_host_top \
    -Mdir obj_dir -o sim_tb > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "build failed"
    exit 1
fi

./obj_dir/sim_tb > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"

if [ $sim_status -eq 0 ] && grep -q '^\*\*\* PASSED \*\*\*$' "$SIM_LOG"; then
    echo "simulation passed"
    exit 0
fi
echo "simulation failed (exit status $sim_status)"
exit 1
